//--- hdl/back_end_settings.svh
// Tag width must stay equal to log2 of the reorder buffer depth because tags index the slots
`ifndef BACK_END_SETTINGS_SVH
`define BACK_END_SETTINGS_SVH

// ====================
// Datapath widths
// ====================

`define BE_DATA_W 32
`define BE_REG_W 5

// ====================
// Reorder buffer and pipes
// ====================

// Each entry is also one issue credit
`define BE_ROB_DEPTH 8
`define BE_TAG_W 3
`define BE_MUL_LAT 3

`endif

//--- hdl/core_types_pkg.sv
// Data and tag types for every stage of the back end, sized by the settings header
`include "back_end_settings.svh"

package core_types_pkg;

    // ====================
    // Scalar types
    // ====================

    // One architectural data word
    typedef logic [`BE_DATA_W-1:0] data_word_t;

    // Architectural register index as seen by the issuer
    typedef logic [`BE_REG_W-1:0] reg_idx_t;

    // Reorder buffer slot, which doubles as the program order tag
    typedef logic [`BE_TAG_W-1:0] rob_tag_t;

    // ====================
    // Reorder buffer entry
    // ====================

    // The destination is written at issue
    // The result and the exception flag arrive at completion
    typedef struct packed {
        reg_idx_t   dest;
        data_word_t result;
        logic       exception;
    } rob_entry_t;

endpackage : core_types_pkg

//--- hdl/exec_ops_pkg.sv
// Opcode and slot state encodings that only the back end and its issuer share
package exec_ops_pkg;

    // ====================
    // Opcodes
    // ====================

    // Only the multiply uses the long pipe
    // A trap only raises an exception at retire
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_TRAP
    } exec_op_e;

    // Life of a reorder buffer slot from issue to retire
    typedef enum logic [1:0] {
        ST_FREE,
        ST_PENDING,
        ST_DONE
    } rob_state_e;

endpackage : exec_ops_pkg

//--- hdl/back_end_ifs.sv
// Both interfaces are purely combinational bundles and carry no clock of their own
// ====================
// Completion path
// ====================

// One result per cycle from an execute path into the reorder buffer
interface completion_if;
    import core_types_pkg::*;

    logic       valid;
    rob_tag_t   tag;
    reg_idx_t   dest;
    data_word_t result;
    logic       exception;

    modport producer (output valid, output tag, output dest, output result, output exception);
    modport consumer (input valid, input tag, input dest, input result, input exception);
endinterface : completion_if

// ====================
// Forwarding lookup
// ====================

// Two source lookups answered in the same cycle by the reorder buffer
interface fwd_if;
    import core_types_pkg::*;

    reg_idx_t   [1:0] src;
    logic       [1:0] hit;
    data_word_t [1:0] data;

    modport requester (output src, input hit, input data);
    modport responder (input src, output hit, output data);
endinterface : fwd_if

//--- hdl/operand_bypass.sv
// Only finished reorder buffer results are forwarded and a pending producer leaves the issue value
module operand_bypass (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              issue_valid_i,
    input  exec_ops_pkg::exec_op_e            issue_op_i,
    input  core_types_pkg::rob_tag_t          issue_tag_i,
    input  core_types_pkg::reg_idx_t          issue_dest_i,
    input  core_types_pkg::reg_idx_t   [1:0]  issue_src_i,
    input  core_types_pkg::data_word_t [1:0]  issue_operand_i,
    fwd_if.requester                          fwd,
    output logic                              ex_valid_o,
    output exec_ops_pkg::exec_op_e            ex_op_o,
    output core_types_pkg::rob_tag_t          ex_tag_o,
    output core_types_pkg::reg_idx_t          ex_dest_o,
    output core_types_pkg::data_word_t [1:0]  ex_operand_o
);
    import core_types_pkg::*;

    // Operands after the forwarding choice
    data_word_t [1:0] operand_sel;

    // The lookup sees the reorder buffer as it stands before this edge
    assign fwd.src = issue_src_i;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            // A hit means the youngest writer of this register has finished
            operand_sel[k] = fwd.hit[k] ? fwd.data[k] : issue_operand_i[k];
        end
    end

    // ====================
    // Issue register
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_valid_i;
        end
    end

    // Instruction payload handed to the execute stage
    always_ff @(posedge clk_i) begin
        ex_op_o      <= issue_op_i;
        ex_tag_o     <= issue_tag_i;
        ex_dest_o    <= issue_dest_i;
        ex_operand_o <= operand_sel;
    end

    // The issuer has to hold off during the flush cycle that the reorder buffer raises
    issue_during_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> !issue_valid_i)
        else $error("issue_valid_i asserted while flush_i is high");

endmodule : operand_bypass

//--- hdl/exec_unit.sv
// Multiply keeps only the low word of the product and a trap completes with a zero result
`include "back_end_settings.svh"

module exec_unit (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              ex_valid_i,
    input  exec_ops_pkg::exec_op_e            ex_op_i,
    input  core_types_pkg::rob_tag_t          ex_tag_i,
    input  core_types_pkg::reg_idx_t          ex_dest_i,
    input  core_types_pkg::data_word_t [1:0]  ex_operand_i,
    completion_if.producer                    cpl_alu,
    completion_if.producer                    cpl_mul
);
    import core_types_pkg::*;
    import exec_ops_pkg::*;

    // ====================
    // ALU path
    // ====================

    data_word_t alu_value;
    logic       alu_valid_q;
    rob_tag_t   alu_tag_q;
    reg_idx_t   alu_dest_q;
    data_word_t alu_result_q;
    logic       alu_exc_q;

    always_comb begin
        case (ex_op_i)
            OP_ADD:  alu_value = ex_operand_i[0] + ex_operand_i[1];
            OP_SUB:  alu_value = ex_operand_i[0] - ex_operand_i[1];
            OP_AND:  alu_value = ex_operand_i[0] & ex_operand_i[1];
            OP_OR:   alu_value = ex_operand_i[0] | ex_operand_i[1];
            OP_XOR:  alu_value = ex_operand_i[0] ^ ex_operand_i[1];
            // Trap carries a zero result and the multiply never uses this path
            default: alu_value = '0;
        endcase
    end

    // ====================
    // Multiply pipe
    // ====================

    // Stage 0 holds the fresh product and the last stage reports it
    data_word_t                 mul_low;
    logic [`BE_MUL_LAT-1:0]     mul_valid_q;
    rob_tag_t                   mul_tag_q    [`BE_MUL_LAT];
    reg_idx_t                   mul_dest_q   [`BE_MUL_LAT];
    data_word_t                 mul_result_q [`BE_MUL_LAT];

    // Assigning to one word drops the upper half of the product
    assign mul_low = ex_operand_i[0] * ex_operand_i[1];

    // Valid bits of both paths are the only control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= '0;
        end else begin
            alu_valid_q <= ex_valid_i && (ex_op_i != OP_MUL);
            mul_valid_q <= {mul_valid_q[`BE_MUL_LAT-2:0], ex_valid_i && (ex_op_i == OP_MUL)};
        end
    end

    always_ff @(posedge clk_i) begin
        alu_tag_q       <= ex_tag_i;
        alu_dest_q      <= ex_dest_i;
        alu_result_q    <= alu_value;
        alu_exc_q       <= (ex_op_i == OP_TRAP);
        mul_tag_q[0]    <= ex_tag_i;
        mul_dest_q[0]   <= ex_dest_i;
        mul_result_q[0] <= mul_low;
        // Up to three multiplies move one stage per cycle
        for (int s = 1; s < `BE_MUL_LAT; s++) begin
            mul_tag_q[s]    <= mul_tag_q[s-1];
            mul_dest_q[s]   <= mul_dest_q[s-1];
            mul_result_q[s] <= mul_result_q[s-1];
        end
    end

    // ====================
    // Completions
    // ====================

    assign cpl_alu.valid     = alu_valid_q;
    assign cpl_alu.tag       = alu_tag_q;
    assign cpl_alu.dest      = alu_dest_q;
    assign cpl_alu.result    = alu_result_q;
    assign cpl_alu.exception = alu_exc_q;

    // A multiply never raises an exception
    assign cpl_mul.valid     = mul_valid_q[`BE_MUL_LAT-1];
    assign cpl_mul.tag       = mul_tag_q[`BE_MUL_LAT-1];
    assign cpl_mul.dest      = mul_dest_q[`BE_MUL_LAT-1];
    assign cpl_mul.result    = mul_result_q[`BE_MUL_LAT-1];
    assign cpl_mul.exception = 1'b0;

endmodule : exec_unit

//--- hdl/reorder_buffer.sv
// Slots are indexed by tag so the issuer must hand out tags in order and only while credits remain
`include "back_end_settings.svh"

module reorder_buffer (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    completion_if.consumer              cpl_alu,
    completion_if.consumer              cpl_mul,
    fwd_if.responder                    fwd,
    input  logic                        issue_valid_i,
    input  core_types_pkg::rob_tag_t    issue_tag_i,
    input  core_types_pkg::reg_idx_t    issue_dest_i,
    output logic                        credit_o,
    output logic                        wb_valid_o,
    output core_types_pkg::reg_idx_t    wb_dest_o,
    output core_types_pkg::data_word_t  wb_data_o,
    output logic                        exception_o,
    output logic                        flush_o
);
    import core_types_pkg::*;
    import exec_ops_pkg::*;

    // ====================
    // Slot storage
    // ====================

    rob_state_e state_q [`BE_ROB_DEPTH];
    rob_entry_t entry_q [`BE_ROB_DEPTH];
    rob_tag_t   head_q;
    rob_entry_t head_entry;
    logic       retire;
    logic       trap_q;

    assign head_entry = entry_q[head_q];

    // The head leaves as soon as its result is in
    assign retire = (state_q[head_q] == ST_DONE);

    // Issue, completion and retire never touch the same slot in one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_o) begin
            for (int i = 0; i < `BE_ROB_DEPTH; i++) begin
                state_q[i] <= ST_FREE;
            end
            head_q <= '0;
        end else begin
            if (issue_valid_i) begin
                state_q[issue_tag_i] <= ST_PENDING;
            end
            if (cpl_alu.valid) begin
                state_q[cpl_alu.tag] <= ST_DONE;
            end
            if (cpl_mul.valid) begin
                state_q[cpl_mul.tag] <= ST_DONE;
            end
            if (retire) begin
                state_q[head_q] <= ST_FREE;
                head_q          <= head_q + rob_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            entry_q[issue_tag_i].dest <= issue_dest_i;
        end
        if (cpl_alu.valid) begin
            entry_q[cpl_alu.tag].result    <= cpl_alu.result;
            entry_q[cpl_alu.tag].exception <= cpl_alu.exception;
        end
        if (cpl_mul.valid) begin
            entry_q[cpl_mul.tag].result    <= cpl_mul.result;
            entry_q[cpl_mul.tag].exception <= cpl_mul.exception;
        end
    end

    // ====================
    // Retire outputs
    // ====================

    // A normal retire writes back and returns its credit in the same pulse
    // A trap entry flushes instead and its credit comes back with the flush
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_o) begin
            wb_valid_o <= 1'b0;
            trap_q     <= 1'b0;
        end else begin
            wb_valid_o <= retire && !head_entry.exception;
            trap_q     <= retire && head_entry.exception;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_dest_o <= head_entry.dest;
        wb_data_o <= head_entry.result;
    end

    assign credit_o    = wb_valid_o;
    assign exception_o = trap_q;
    assign flush_o     = trap_q;

    // ====================
    // Forwarding
    // ====================

    // Walk from the head so that a younger writer overrides an older one
    always_comb begin
        rob_tag_t scan_idx;
        for (int k = 0; k < 2; k++) begin
            fwd.hit[k]  = 1'b0;
            fwd.data[k] = '0;
            for (int a = 0; a < `BE_ROB_DEPTH; a++) begin
                scan_idx = head_q + rob_tag_t'(a);
                if (state_q[scan_idx] != ST_FREE && entry_q[scan_idx].dest == fwd.src[k]) begin
                    fwd.hit[k]  = (state_q[scan_idx] == ST_DONE);
                    fwd.data[k] = entry_q[scan_idx].result;
                end
            end
        end
    end

    // Execute must only report tags that were issued and not yet finished
    alu_cpl_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cpl_alu.valid |-> state_q[cpl_alu.tag] == ST_PENDING)
        else $error("ALU completion on a slot that is not pending");

    mul_cpl_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cpl_mul.valid |-> state_q[cpl_mul.tag] == ST_PENDING)
        else $error("multiply completion on a slot that is not pending");

    // An occupied target slot means the issuer went past its credits
    issue_slot_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i |-> state_q[issue_tag_i] == ST_FREE)
        else $error("issue into an occupied slot with no credit left");

endmodule : reorder_buffer

//--- hdl/back_end.sv
// The issuer must follow the credit rule and stay idle in the cycle where flush_o is high
module back_end (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              issue_valid_i,
    input  exec_ops_pkg::exec_op_e            issue_op_i,
    input  core_types_pkg::rob_tag_t          issue_tag_i,
    input  core_types_pkg::reg_idx_t          issue_dest_i,
    input  core_types_pkg::reg_idx_t   [1:0]  issue_src_i,
    input  core_types_pkg::data_word_t [1:0]  issue_operand_i,
    output logic                              credit_o,
    output logic                              wb_valid_o,
    output core_types_pkg::reg_idx_t          wb_dest_o,
    output core_types_pkg::data_word_t        wb_data_o,
    output logic                              flush_o,
    output logic                              exception_o
);
    import core_types_pkg::*;
    import exec_ops_pkg::*;

    // ====================
    // Stage links
    // ====================

    // Results reach the reorder buffer on two paths that may finish together
    completion_if cpl_alu ();
    completion_if cpl_mul ();
    fwd_if        fwd ();

    // Registered instruction between bypass and execute
    logic             ex_valid;
    exec_op_e         ex_op;
    rob_tag_t         ex_tag;
    reg_idx_t         ex_dest;
    data_word_t [1:0] ex_operand;

    // ====================
    // Stages
    // ====================

    // The flush from the trap retire empties the front stages as well
    operand_bypass u_bypass (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_o         ),
        .issue_valid_i   ( issue_valid_i   ),
        .issue_op_i      ( issue_op_i      ),
        .issue_tag_i     ( issue_tag_i     ),
        .issue_dest_i    ( issue_dest_i    ),
        .issue_src_i     ( issue_src_i     ),
        .issue_operand_i ( issue_operand_i ),
        .fwd             ( fwd             ),
        .ex_valid_o      ( ex_valid        ),
        .ex_op_o         ( ex_op           ),
        .ex_tag_o        ( ex_tag          ),
        .ex_dest_o       ( ex_dest         ),
        .ex_operand_o    ( ex_operand      )
    );

    exec_unit u_exec (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .flush_i      ( flush_o    ),
        .ex_valid_i   ( ex_valid   ),
        .ex_op_i      ( ex_op      ),
        .ex_tag_i     ( ex_tag     ),
        .ex_dest_i    ( ex_dest    ),
        .ex_operand_i ( ex_operand ),
        .cpl_alu      ( cpl_alu    ),
        .cpl_mul      ( cpl_mul    )
    );

    // Slots are claimed straight from the issue ports
    reorder_buffer u_rob (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .cpl_alu       ( cpl_alu       ),
        .cpl_mul       ( cpl_mul       ),
        .fwd           ( fwd           ),
        .issue_valid_i ( issue_valid_i ),
        .issue_tag_i   ( issue_tag_i   ),
        .issue_dest_i  ( issue_dest_i  ),
        .credit_o      ( credit_o      ),
        .wb_valid_o    ( wb_valid_o    ),
        .wb_dest_o     ( wb_dest_o     ),
        .wb_data_o     ( wb_data_o     ),
        .exception_o   ( exception_o   ),
        .flush_o       ( flush_o       )
    );

endmodule : back_end

//--- tb/back_end_tb.sv
// Tests never read a register whose youngest writer is still pending since the back end does not forward it
`include "back_end_settings.svh"

module back_end_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_types_pkg::*;
    import exec_ops_pkg::*;

    localparam int NUM_REGS    = 1 << `BE_REG_W;
    // Cycle budget of reset and the five tests for the watchdog
    localparam int TEST_CYCLES = 5 + 30 + 30 + 30 + 60 + 50;

    typedef struct packed {
        reg_idx_t   dest;
        data_word_t data;
        logic       trap;
    } expect_t;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic issue_valid_i;
    exec_op_e issue_op_i;
    rob_tag_t issue_tag_i;
    reg_idx_t issue_dest_i;
    reg_idx_t [1:0] issue_src_i;
    data_word_t [1:0] issue_operand_i;
    logic credit_o;
    logic wb_valid_o;
    logic flush_o;
    logic exception_o;
    reg_idx_t wb_dest_o;
    data_word_t wb_data_o;

    // Committed register file of the issuer, and the program order view of it
    data_word_t arf [NUM_REGS];
    data_word_t spec [NUM_REGS];
    expect_t exp_q [$];
    int credits = `BE_ROB_DEPTH;
    rob_tag_t next_tag = '0;
    int value_errors = 0;
    int other_errors = 0;
    int wb_count = 0;
    int credit_count = 0;
    int flush_count = 0;
    logic [15:0] lfsr_q = 16'd35540;

    always #20 clk_i = ~clk_i;

    back_end back_end_i (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .issue_valid_i   ( issue_valid_i   ),
        .issue_op_i      ( issue_op_i      ),
        .issue_tag_i     ( issue_tag_i     ),
        .issue_dest_i    ( issue_dest_i    ),
        .issue_src_i     ( issue_src_i     ),
        .issue_operand_i ( issue_operand_i ),
        .credit_o        ( credit_o        ),
        .wb_valid_o      ( wb_valid_o      ),
        .wb_dest_o       ( wb_dest_o       ),
        .wb_data_o       ( wb_data_o       ),
        .flush_o         ( flush_o         ),
        .exception_o     ( exception_o     )
    );

    // ====================
    // Helpers
    // ====================

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic data_word_t take_bits(input int n);
        data_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[`BE_DATA_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // Result rules per opcode
    // A multiply keeps the low word and a trap yields zero
    function automatic data_word_t expected_result(input exec_op_e op, input data_word_t a,
                                                   input data_word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // ====================
    // Issuer and monitor
    // ====================

    // Called 2 ns after an edge, returns 2 ns after the edge that sampled the issue
    task automatic issue_instr(input exec_op_e op, input reg_idx_t dest, input reg_idx_t src0,
                               input reg_idx_t src1);
        expect_t e;
        // Hold off with no credit left and during the flush cycle
        while (credits == 0 || flush_o) begin
            @(posedge clk_i);
            #2;
        end
        issue_valid_i      = 1'b1;
        issue_op_i         = op;
        issue_tag_i        = next_tag;
        issue_dest_i       = dest;
        issue_src_i[0]     = src0;
        issue_src_i[1]     = src1;
        // Operands come from the committed file and may be stale
        issue_operand_i[0] = arf[src0];
        issue_operand_i[1] = arf[src1];
        e.dest = dest;
        e.data = expected_result(op, spec[src0], spec[src1]);
        e.trap = (op == OP_TRAP);
        exp_q.push_back(e);
        if (op != OP_TRAP) begin
            spec[dest] = e.data;
        end
        credits--;
        next_tag++;
        @(posedge clk_i);
        #2;
        issue_valid_i = 1'b0;
    endtask

    // Waits until nothing is in flight, then a little longer to catch stray writebacks
    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #2;
        end
        repeat (2) begin
            @(posedge clk_i);
            #2;
        end
        if (credits != `BE_ROB_DEPTH) begin
            report_failure("credits did not return to the full count when idle");
        end
    endtask

    task automatic check_retire();
        expect_t e;
        wb_count++;
        check_flag("credit_o", credit_o, 1'b1);
        if (exp_q.size() == 0) begin
            report_failure("writeback with no instruction in flight");
        end else begin
            e = exp_q.pop_front();
            if (e.trap) begin
                report_failure("trap instruction wrote back instead of flushing");
            end
            check_reg("wb_dest_o", wb_dest_o, e.dest);
            check_word("wb_data_o", wb_data_o, e.data);
            arf[e.dest] = e.data;
        end
    endtask

    // A trap at the head drops everything younger and restores full credits at tag 0
    task automatic check_flush();
        flush_count++;
        check_flag("exception_o", exception_o, 1'b1);
        check_flag("credit_o", credit_o, 1'b0);
        if (exp_q.size() == 0 || !exp_q[0].trap) begin
            report_failure("flush without a trap instruction at the head");
        end
        exp_q.delete();
        credits  = `BE_ROB_DEPTH;
        next_tag = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            spec[r] = arf[r];
        end
    endtask

    // Outputs are registered, so 1 ns after the edge they are stable
    always begin
        @(posedge clk_i);
        #1;
        if (rst_n_i) begin
            if (wb_valid_o && flush_o) begin
                report_failure("writeback and flush in the same cycle");
            end
            if (wb_valid_o) begin
                check_retire();
            end
            if (flush_o) begin
                check_flush();
            end else if (exception_o) begin
                report_failure("exception_o high without flush_o");
            end
            if (credit_o) begin
                credit_count++;
                credits++;
                if (credits > `BE_ROB_DEPTH) begin
                    report_failure("more credits returned than were issued");
                end
            end
        end
    end

    // ====================
    // Directed tests
    // ====================

    task automatic alu_ops_test();
        exec_op_e ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        int wb_start;
        int credit_start;
        wb_start     = wb_count;
        credit_start = credit_count;
        for (int k = 0; k < 5; k++) begin
            issue_instr(ops[k], reg_idx_t'(1 + k), reg_idx_t'(16 + 2 * k), reg_idx_t'(17 + 2 * k));
        end
        wait_idle();
        if (wb_count - wb_start != 5 || credit_count - credit_start != 5) begin
            report_failure("ALU test did not see five writebacks with five credit pulses");
        end
    endtask

    // The ADDs finish before the multiply but must retire after it
    task automatic mul_order_test();
        issue_instr(OP_MUL, 5'd6, 5'd18, 5'd19);
        issue_instr(OP_ADD, 5'd7, 5'd20, 5'd21);
        issue_instr(OP_ADD, 5'd8, 5'd22, 5'd23);
        issue_instr(OP_ADD, 5'd9, 5'd24, 5'd25);
        wait_idle();
    endtask

    // The multiply holds the head so the ADD is done but not committed when the SUB reads it
    task automatic forward_test();
        issue_instr(OP_MUL, 5'd12, 5'd20, 5'd21);
        issue_instr(OP_ADD, 5'd10, 5'd22, 5'd23);
        @(posedge clk_i);
        #2;
        @(posedge clk_i);
        #2;
        issue_instr(OP_SUB, 5'd11, 5'd10, 5'd24);
        wait_idle();
    endtask

    task automatic credit_test();
        for (int batch = 0; batch < 2; batch++) begin
            for (int k = 0; k < `BE_ROB_DEPTH; k++) begin
                issue_instr((k % 2 == 0) ? OP_MUL : OP_ADD, reg_idx_t'(1 + k),
                            reg_idx_t'(16 + k), reg_idx_t'(31 - k));
            end
            // Let the credit pulses bring the count back before the next batch
            wait_idle();
        end
    endtask

    task automatic trap_test();
        int flush_start;
        flush_start = flush_count;
        issue_instr(OP_ADD, 5'd1, 5'd16, 5'd17);
        issue_instr(OP_SUB, 5'd2, 5'd18, 5'd19);
        issue_instr(OP_TRAP, 5'd3, 5'd20, 5'd21);
        issue_instr(OP_ADD, 5'd4, 5'd22, 5'd23);
        issue_instr(OP_XOR, 5'd5, 5'd24, 5'd25);
        wait_idle();
        if (flush_count - flush_start != 1) begin
            report_failure("trap did not produce exactly one flush pulse");
        end
        // Restart at tag 0, reading the registers that the older instructions committed
        issue_instr(OP_ADD, 5'd6, 5'd1, 5'd2);
        issue_instr(OP_MUL, 5'd7, 5'd2, 5'd26);
        wait_idle();
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rst_n_i            = 1'b0;
        issue_valid_i      = 1'b0;
        issue_op_i         = OP_ADD;
        issue_tag_i        = '0;
        issue_dest_i       = '0;
        issue_src_i        = '0;
        issue_operand_i    = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            arf[r]  = take_bits(`BE_DATA_W);
            spec[r] = arf[r];
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_flag("credit_o", credit_o, 1'b0);
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
        check_flag("flush_o", flush_o, 1'b0);
        check_flag("exception_o", exception_o, 1'b0);
        alu_ops_test();
        mul_order_test();
        forward_test();
        credit_test();
        trap_test();
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths plus a margin
    initial begin
        #(TEST_CYCLES * 40 + 2000);
        $display("Timeout: the tests did not finish within the time limit");
        $display("Verification failed");
        $finish;
    end

endmodule : back_end_tb

//--- back_end.f
+incdir+hdl
hdl/core_types_pkg.sv
hdl/exec_ops_pkg.sv
hdl/back_end_ifs.sv
hdl/operand_bypass.sv
hdl/exec_unit.sv
hdl/reorder_buffer.sv
hdl/back_end.sv
tb/back_end_tb.sv

//--- Makefile
# Verilator build and run of the back end testbench
TOP      ?= back_end_tb
FILELIST ?= back_end.f
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: TOP FILELIST LOG VFLAGS OBJ_DIR"

test:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
